/* verilog/soc_cfg_pkg.sv */
// --------------------------------------------------
// system configuration of the reduced SoC fabric
// address map, L2 geometry and the limit on
// transactions in flight, imported wherever needed
// --------------------------------------------------
`default_nettype none

package soc_cfg_pkg;

  // L2 window
  localparam logic [31:0] L2_BASE_ADDR = 32'h1C00_0000;
  localparam int unsigned L2_SIZE      = 4096;
  // 64-bit words
  localparam int unsigned L2_WORDS     = L2_SIZE / 8;
  localparam int unsigned L2_IDX_W     = $clog2(L2_WORDS);

  // external window, up to the top of the address space
  localparam logic [31:0] EXT_BASE_ADDR = 32'h8000_0000;

  // slots in the ID remapper, also depth of the order queue
  localparam int unsigned N_OUTSTANDING = 4;
  // occupancy counter, counts 0 to N_OUTSTANDING
  localparam int unsigned OUT_CNT_W     = $clog2(N_OUTSTANDING + 1);

endpackage

`default_nettype wire

/* verilog/soc_bus_pkg.sv */
// --------------------------------------------------
// field types of the SoC bus
// address, data, strobe and the two ID widths, plus
// the routing targets of the address decoder
// --------------------------------------------------
`default_nettype none

package soc_bus_pkg;
  import soc_cfg_pkg::*;

  // byte address and one data beat
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [$bits(data_t)/8-1:0] strb_t;

  // host side ID
  typedef logic [7:0] id_ext_t;
  // slot index inside the fabric
  typedef logic [$clog2(N_OUTSTANDING)-1:0] id_int_t;

  // where a request goes after decode
  typedef enum logic [1:0] {
    TGT_L2,
    TGT_EXT,
    TGT_ERR
  } target_e;

endpackage

`default_nettype wire

/* verilog/soc_bus_if.sv */
// --------------------------------------------------
// request and response channels of the SoC bus
// valid/ready handshake, single beat per transfer
// the ID type is set per instance, host or internal
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface bus_req_if import soc_bus_pkg::*; #(
  parameter type id_t = id_int_t
) ();

  logic  req_valid;
  logic  req_ready;
  addr_t addr;
  logic  we;
  data_t wdata;
  strb_t strb;
  id_t   id;

  modport initiator (
    output req_valid, addr, we, wdata, strb, id,
    input  req_ready
  );

  modport target (
    input  req_valid, addr, we, wdata, strb, id,
    output req_ready
  );

endinterface

interface bus_rsp_if import soc_bus_pkg::*; #(
  parameter type id_t = id_int_t
) ();

  logic  rsp_valid;
  logic  rsp_ready;
  data_t rdata;
  logic  err;
  id_t   id;

  // the target answers, the initiator only accepts
  modport target (
    output rsp_valid, rdata, err, id,
    input  rsp_ready
  );

  modport initiator (
    input  rsp_valid, rdata, err, id,
    output rsp_ready
  );

endinterface

`default_nettype wire

/* verilog/id_remap.sv */
// --------------------------------------------------
// host ID remapper
// narrows 8-bit host IDs to internal slot IDs and
// puts the host ID back on the way out; no added
// cycle on either path
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module id_remap import soc_cfg_pkg::*; import soc_bus_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  arst_n_i,
  bus_req_if.target  host_req,
  bus_rsp_if.target  host_rsp,
  bus_req_if.initiator bus_req,
  bus_rsp_if.initiator bus_rsp
);

  // slot table
  logic    busy_q     [N_OUTSTANDING];
  id_ext_t saved_id_q [N_OUTSTANDING];

  logic    any_free;
  id_int_t free_idx;
  id_int_t alloc_idx;
  logic    req_fire;
  logic    rsp_fire;

  // slot held for a request that waits on the bus
  logic    lock_q;
  id_int_t lock_idx_q;

  // lowest free slot wins
  always_comb begin
    any_free = 1'b0;
    free_idx = '0;
    for (int i = N_OUTSTANDING - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        any_free = 1'b1;
        free_idx = id_int_t'(i);
      end
    end
  end

  // keeps the internal ID stable while the request stalls
  assign alloc_idx = lock_q ? lock_idx_q : free_idx;

  assign bus_req.req_valid = host_req.req_valid && any_free;
  assign bus_req.addr      = host_req.addr;
  assign bus_req.we        = host_req.we;
  assign bus_req.wdata     = host_req.wdata;
  assign bus_req.strb      = host_req.strb;
  assign bus_req.id        = alloc_idx;
  assign host_req.req_ready = bus_req.req_ready && any_free;

  assign req_fire = bus_req.req_valid && bus_req.req_ready;

  // response side, restore the host ID
  assign host_rsp.rsp_valid = bus_rsp.rsp_valid;
  assign host_rsp.rdata     = bus_rsp.rdata;
  assign host_rsp.err       = bus_rsp.err;
  assign host_rsp.id        = saved_id_q[bus_rsp.id];
  assign bus_rsp.rsp_ready  = host_rsp.rsp_ready;

  assign rsp_fire = bus_rsp.rsp_valid && bus_rsp.rsp_ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < N_OUTSTANDING; i++) begin
        busy_q[i] <= 1'b0;
      end
      lock_q <= 1'b0;
    end else begin
      // a freed slot and a new one never coincide
      if (rsp_fire) begin
        busy_q[bus_rsp.id] <= 1'b0;
      end
      if (req_fire) begin
        busy_q[alloc_idx] <= 1'b1;
      end
      lock_q <= bus_req.req_valid && !bus_req.req_ready;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      saved_id_q[alloc_idx] <= host_req.id;
    end
    if (bus_req.req_valid && !bus_req.req_ready) begin
      lock_idx_q <= alloc_idx;
    end
  end

endmodule

`default_nettype wire

/* verilog/soc_bus.sv */
// --------------------------------------------------
// SoC bus with a single host-side slave port
// decodes each address to L2, the external master
// port or a decode error, and returns responses in
// request order through a small order queue
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module soc_bus import soc_cfg_pkg::*; import soc_bus_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    arst_n_i,
  bus_req_if.target    slv_req,
  bus_rsp_if.target    slv_rsp,
  bus_req_if.initiator l2_req,
  bus_rsp_if.initiator l2_rsp,
  bus_req_if.initiator ext_req,
  bus_rsp_if.initiator ext_rsp
);

  addr_t   l2_offset;
  target_e req_tgt;
  logic    tgt_ready;
  logic    push;
  logic    pop;

  // order queue
  target_e tgt_q [N_OUTSTANDING];
  id_int_t id_q  [N_OUTSTANDING];
  id_int_t wr_ptr_q;
  id_int_t rd_ptr_q;
  logic [OUT_CNT_W-1:0] count_q;
  logic    full;
  logic    empty;
  target_e head_tgt;
  id_int_t head_id;

  // address decode
  assign l2_offset = slv_req.addr - L2_BASE_ADDR;

  always_comb begin
    if (slv_req.addr >= EXT_BASE_ADDR) begin
      req_tgt = TGT_EXT;
    end else if (slv_req.addr >= L2_BASE_ADDR && l2_offset < L2_SIZE) begin
      req_tgt = TGT_L2;
    end else begin
      req_tgt = TGT_ERR;
    end
  end

  assign full  = (count_q == OUT_CNT_W'(N_OUTSTANDING));
  assign empty = (count_q == '0);

  // valid goes to the decoded target only
  assign l2_req.req_valid  = slv_req.req_valid && !full && (req_tgt == TGT_L2);
  assign ext_req.req_valid = slv_req.req_valid && !full && (req_tgt == TGT_EXT);

  assign l2_req.addr   = slv_req.addr;
  assign l2_req.we     = slv_req.we;
  assign l2_req.wdata  = slv_req.wdata;
  assign l2_req.strb   = slv_req.strb;
  assign l2_req.id     = slv_req.id;
  assign ext_req.addr  = slv_req.addr;
  assign ext_req.we    = slv_req.we;
  assign ext_req.wdata = slv_req.wdata;
  assign ext_req.strb  = slv_req.strb;
  assign ext_req.id    = slv_req.id;

  // decode errors are taken at once
  always_comb begin
    unique case (req_tgt)
      TGT_L2:  tgt_ready = l2_req.req_ready;
      TGT_EXT: tgt_ready = ext_req.req_ready;
      default: tgt_ready = 1'b1;
    endcase
  end

  assign slv_req.req_ready = !full && (!slv_req.req_valid || tgt_ready);
  assign push = slv_req.req_valid && slv_req.req_ready;

  assign head_tgt = tgt_q[rd_ptr_q];
  assign head_id  = id_q[rd_ptr_q];

  // response from the head's target only
  always_comb begin
    slv_rsp.rsp_valid = 1'b0;
    slv_rsp.rdata     = '0;
    slv_rsp.err       = 1'b0;
    slv_rsp.id        = head_id;
    l2_rsp.rsp_ready  = 1'b0;
    ext_rsp.rsp_ready = 1'b0;
    if (!empty) begin
      unique case (head_tgt)
        TGT_L2: begin
          slv_rsp.rsp_valid = l2_rsp.rsp_valid;
          slv_rsp.rdata     = l2_rsp.rdata;
          slv_rsp.err       = l2_rsp.err;
          slv_rsp.id        = l2_rsp.id;
          l2_rsp.rsp_ready  = slv_rsp.rsp_ready;
        end
        TGT_EXT: begin
          slv_rsp.rsp_valid = ext_rsp.rsp_valid;
          slv_rsp.rdata     = ext_rsp.rdata;
          slv_rsp.err       = ext_rsp.err;
          ext_rsp.rsp_ready = slv_rsp.rsp_ready;
        end
        default: begin
          slv_rsp.rsp_valid = 1'b1;
          slv_rsp.err       = 1'b1;
        end
      endcase
    end
  end

  assign pop = slv_rsp.rsp_valid && slv_rsp.rsp_ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      tgt_q[wr_ptr_q] <= req_tgt;
      id_q[wr_ptr_q]  <= slv_req.id;
    end
  end

endmodule

`default_nettype wire

/* verilog/l2_mem.sv */
// --------------------------------------------------
// on-chip L2 memory, 64-bit words, single port
// byte strobes on writes; the response sits in a
// one-entry register one cycle after acceptance
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module l2_mem import soc_cfg_pkg::*; import soc_bus_pkg::*; (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  bus_req_if.target req,
  bus_rsp_if.target rsp
);

  data_t mem_q [L2_WORDS];

  addr_t                offset;
  logic [L2_IDX_W-1:0]  word_idx;
  logic                 req_fire;

  logic    rsp_valid_q;
  data_t   rsp_rdata_q;
  id_int_t rsp_id_q;

  assign offset   = req.addr - L2_BASE_ADDR;
  assign word_idx = offset[3 +: L2_IDX_W];

  // free slot, or the held response leaves now
  assign req.req_ready = !rsp_valid_q || rsp.rsp_ready;
  assign req_fire      = req.req_valid && req.req_ready;

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req.we) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (req.strb[b]) begin
            mem_q[word_idx][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
        // writes answer with zero data
        rsp_rdata_q <= '0;
      end else begin
        rsp_rdata_q <= mem_q[word_idx];
      end
      rsp_id_q <= req.id;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp.rsp_valid = rsp_valid_q;
  assign rsp.rdata     = rsp_rdata_q;
  assign rsp.err       = 1'b0;
  assign rsp.id        = rsp_id_q;

endmodule

`default_nettype wire

/* verilog/pulp_soc.sv */
// --------------------------------------------------
// top level of the reduced SoC fabric
// host slave port -> ID remapper -> SoC bus, which
// feeds the L2 memory and the external master port
// all ports are plain signals, interfaces stay inside
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pulp_soc import soc_bus_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    arst_n_i,
  // host requests in
  input  wire logic    host_req_valid_i,
  output logic         host_req_ready_o,
  input  wire addr_t   host_req_addr_i,
  input  wire logic    host_req_we_i,
  input  wire data_t   host_req_wdata_i,
  input  wire strb_t   host_req_strb_i,
  input  wire id_ext_t host_req_id_i,
  // host responses out
  output logic         host_rsp_valid_o,
  input  wire logic    host_rsp_ready_i,
  output data_t        host_rsp_rdata_o,
  output logic         host_rsp_err_o,
  output id_ext_t      host_rsp_id_o,
  // external master port
  output logic         ext_req_valid_o,
  input  wire logic    ext_req_ready_i,
  output addr_t        ext_req_addr_o,
  output logic         ext_req_we_o,
  output data_t        ext_req_wdata_o,
  output strb_t        ext_req_strb_o,
  output id_int_t      ext_req_id_o,
  input  wire logic    ext_rsp_valid_i,
  output logic         ext_rsp_ready_o,
  input  wire data_t   ext_rsp_rdata_i,
  input  wire logic    ext_rsp_err_i
);

  bus_req_if #(.id_t(id_ext_t)) host_req ();
  bus_rsp_if #(.id_t(id_ext_t)) host_rsp ();
  bus_req_if sb_req ();
  bus_rsp_if sb_rsp ();
  bus_req_if l2_req ();
  bus_rsp_if l2_rsp ();
  bus_req_if ext_req ();
  bus_rsp_if ext_rsp ();

  // host side
  assign host_req.req_valid = host_req_valid_i;
  assign host_req.addr      = host_req_addr_i;
  assign host_req.we        = host_req_we_i;
  assign host_req.wdata     = host_req_wdata_i;
  assign host_req.strb      = host_req_strb_i;
  assign host_req.id        = host_req_id_i;
  assign host_req_ready_o   = host_req.req_ready;
  assign host_rsp_valid_o   = host_rsp.rsp_valid;
  assign host_rsp_rdata_o   = host_rsp.rdata;
  assign host_rsp_err_o     = host_rsp.err;
  assign host_rsp_id_o      = host_rsp.id;
  assign host_rsp.rsp_ready = host_rsp_ready_i;

  // external side, response ID comes from the order queue
  assign ext_req_valid_o   = ext_req.req_valid;
  assign ext_req_addr_o    = ext_req.addr;
  assign ext_req_we_o      = ext_req.we;
  assign ext_req_wdata_o   = ext_req.wdata;
  assign ext_req_strb_o    = ext_req.strb;
  assign ext_req_id_o      = ext_req.id;
  assign ext_req.req_ready = ext_req_ready_i;
  assign ext_rsp.rsp_valid = ext_rsp_valid_i;
  assign ext_rsp.rdata     = ext_rsp_rdata_i;
  assign ext_rsp.err       = ext_rsp_err_i;
  assign ext_rsp_ready_o   = ext_rsp.rsp_ready;

  id_remap i_id_remap (
    .clk_i,
    .arst_n_i,
    .host_req (host_req),
    .host_rsp (host_rsp),
    .bus_req  (sb_req),
    .bus_rsp  (sb_rsp)
  );

  soc_bus i_soc_bus (
    .clk_i,
    .arst_n_i,
    .slv_req (sb_req),
    .slv_rsp (sb_rsp),
    .l2_req  (l2_req),
    .l2_rsp  (l2_rsp),
    .ext_req (ext_req),
    .ext_rsp (ext_rsp)
  );

  l2_mem i_l2_mem (
    .clk_i,
    .arst_n_i,
    .req (l2_req),
    .rsp (l2_rsp)
  );

endmodule

`default_nettype wire

/* tests/pulp_soc_properties.sv */
// --------------------------------------------------
// handshake and reset properties of the SoC top level
// bound to every pulp_soc instance, watches only
// its plain ports
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pulp_soc_properties import soc_bus_pkg::*; (
  input wire logic    clk_i,
  input wire logic    arst_n_i,
  input wire logic    host_req_ready_o,
  input wire logic    host_rsp_valid_o,
  input wire logic    host_rsp_ready_i,
  input wire data_t   host_rsp_rdata_o,
  input wire logic    host_rsp_err_o,
  input wire id_ext_t host_rsp_id_o,
  input wire logic    ext_req_valid_o,
  input wire logic    ext_req_ready_i,
  input wire addr_t   ext_req_addr_o,
  input wire data_t   ext_req_wdata_o,
  input wire strb_t   ext_req_strb_o
);

  int unsigned fail_cnt = 0;

  // a pending host response holds until it transfers
  rsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_rsp_valid_o && !host_rsp_ready_i |=> host_rsp_valid_o &&
      $stable(host_rsp_rdata_o) && $stable(host_rsp_err_o) && $stable(host_rsp_id_o))
    else begin
      $error("host response dropped or changed before its transfer");
      fail_cnt++;
    end

  // same rule on the external master port
  ext_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ext_req_valid_o && !ext_req_ready_i |=> ext_req_valid_o &&
      $stable(ext_req_addr_o) && $stable(ext_req_wdata_o) && $stable(ext_req_strb_o))
    else begin
      $error("external request dropped or changed before its transfer");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !host_rsp_valid_o && !ext_req_valid_o)
    else begin
      $error("valid output high during reset");
      fail_cnt++;
    end

  ready_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> host_req_ready_o)
    else begin
      $error("host request port not ready after reset");
      fail_cnt++;
    end

endmodule

bind pulp_soc pulp_soc_properties props_inst (.*);

`default_nettype wire

/* tests/tb_pulp_soc.sv */
// --------------------------------------------------
// testbench for the reduced SoC fabric
// drives host requests, plays the external target and
// checks every host response against a queue model of
// the address map and the L2 contents
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_pulp_soc import soc_cfg_pkg::*; import soc_bus_pkg::*; ();

  localparam int WAIT_LIMIT = 200;

  logic    clk_i = 1'b0;
  logic    arst_n_i;
  logic    host_req_valid_i;
  logic    host_req_ready_o;
  addr_t   host_req_addr_i;
  logic    host_req_we_i;
  data_t   host_req_wdata_i;
  strb_t   host_req_strb_i;
  id_ext_t host_req_id_i;
  logic    host_rsp_valid_o;
  logic    host_rsp_ready_i;
  data_t   host_rsp_rdata_o;
  logic    host_rsp_err_o;
  id_ext_t host_rsp_id_o;
  logic    ext_req_valid_o;
  logic    ext_req_ready_i;
  addr_t   ext_req_addr_o;
  logic    ext_req_we_o;
  data_t   ext_req_wdata_o;
  strb_t   ext_req_strb_o;
  id_int_t ext_req_id_o;
  logic    ext_rsp_valid_i;
  logic    ext_rsp_ready_o;
  data_t   ext_rsp_rdata_i;
  logic    ext_rsp_err_i;

  // expected host responses, oldest first
  data_t   exp_data_q [$];
  logic    exp_err_q [$];
  id_ext_t exp_id_q [$];
  addr_t   ext_addr_q [$];
  data_t   l2_model [int];

  // ID slots as the remapper should hold them
  bit      slot_busy [N_OUTSTANDING];
  int      slot_q [$];
  // slot offered to the waiting host request
  int      pick_slot = -1;

  int   seed = 32'hfdc6e9b0;
  int   rsp_seed = 32'hfdc6e9b0;
  int   ext_wait = -1;
  logic ext_taken = 1'b0;
  int   err_cnt = 0;
  int   chk_cnt = 0;

  pulp_soc pulp_soc_inst (.*);

  always #10 clk_i = ~clk_i;

  function automatic target_e target_of(addr_t a);
    if (a >= EXT_BASE_ADDR) begin
      return TGT_EXT;
    end
    if (a >= L2_BASE_ADDR && a < L2_BASE_ADDR + L2_SIZE) begin
      return TGT_L2;
    end
    return TGT_ERR;
  endfunction

  function automatic int total_errors();
    return err_cnt + int'(pulp_soc_inst.props_inst.fail_cnt);
  endfunction

  task automatic report_mismatch(string sig, data_t got, data_t exp);
    $display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
    err_cnt++;
  endtask

  task automatic report_error(string what);
    $display("error at %0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic log_timeout(string what);
    $display("timeout at %0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic end_test(string name, int errs_before);
    $display("test %s done, %0d errors", name, total_errors() - errs_before);
  endtask

  // called 2 ns after a rising edge
  task automatic drive_req(addr_t addr, logic we, strb_t strb);
    host_req_valid_i = 1'b1;
    host_req_addr_i  = addr;
    host_req_we_i    = we;
    host_req_wdata_i = {$random(seed), $random(seed)};
    host_req_strb_i  = strb;
    host_req_id_i    = id_ext_t'($random(seed));
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!host_req_ready_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!host_req_ready_o) begin
      log_timeout("host request was never accepted");
    end else begin
      @(posedge clk_i);
      #2;
      host_req_valid_i = 1'b0;
    end
  endtask

  task automatic send_req(addr_t addr, logic we, strb_t strb);
    drive_req(addr, we, strb);
    wait_accept();
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_data_q.size() != 0 && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (exp_data_q.size() != 0) begin
      log_timeout("host responses still missing");
    end else begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // model update and response checks at the falling edge
  always @(negedge clk_i) begin : monitor
    data_t   exp_data;
    logic    exp_err;
    id_ext_t exp_id;
    data_t   word;
    int      idx;
    int      slot;
    // a waiting request keeps the lowest slot free when it first had one
    if (host_req_valid_i && pick_slot < 0) begin
      for (int s = N_OUTSTANDING - 1; s >= 0; s--) begin
        if (!slot_busy[s]) begin
          pick_slot = s;
        end
      end
    end
    if (host_req_valid_i && host_req_ready_o) begin
      exp_data = '0;
      idx = int'((host_req_addr_i - L2_BASE_ADDR) >> 3);
      case (target_of(host_req_addr_i))
        TGT_L2: begin
          word = l2_model.exists(idx) ? l2_model[idx] : 'x;
          if (host_req_we_i) begin
            for (int b = 0; b < 8; b++) begin
              if (host_req_strb_i[b]) begin
                word[8*b +: 8] = host_req_wdata_i[8*b +: 8];
              end
            end
            l2_model[idx] = word;
          end else begin
            exp_data = word;
          end
        end
        TGT_EXT: begin
          exp_data = {32'h0, ~host_req_addr_i};
          chk_cnt += 5;
          assert (ext_req_addr_o == host_req_addr_i)
            else report_mismatch("ext_req_addr_o", ext_req_addr_o, host_req_addr_i);
          assert (ext_req_wdata_o == host_req_wdata_i)
            else report_mismatch("ext_req_wdata_o", ext_req_wdata_o, host_req_wdata_i);
          assert (ext_req_strb_o == host_req_strb_i)
            else report_mismatch("ext_req_strb_o", ext_req_strb_o, host_req_strb_i);
          assert (ext_req_we_o == host_req_we_i)
            else report_mismatch("ext_req_we_o", data_t'(ext_req_we_o), data_t'(host_req_we_i));
          assert (ext_req_id_o == id_int_t'(pick_slot))
            else report_mismatch("ext_req_id_o", data_t'(ext_req_id_o), data_t'(pick_slot));
        end
        default: begin
          chk_cnt++;
          assert (!ext_req_valid_o)
            else report_error("decode error request raised ext_req_valid_o");
        end
      endcase
      exp_data_q.push_back(exp_data);
      exp_err_q.push_back(target_of(host_req_addr_i) == TGT_ERR);
      exp_id_q.push_back(host_req_id_i);
      if (pick_slot < 0) begin
        report_error("host request accepted with all ID slots busy");
      end else begin
        slot_busy[pick_slot] = 1'b1;
      end
      slot_q.push_back(pick_slot);
      pick_slot = -1;
    end
    if (ext_req_valid_o && ext_req_ready_i) begin
      ext_addr_q.push_back(ext_req_addr_o);
    end
    if (ext_rsp_valid_i && ext_rsp_ready_o) begin
      ext_taken = 1'b1;
    end
    if (host_rsp_valid_o && host_rsp_ready_i) begin
      if (exp_data_q.size() == 0) begin
        report_error("host response without an open request");
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_err  = exp_err_q.pop_front();
        exp_id   = exp_id_q.pop_front();
        slot     = slot_q.pop_front();
        if (slot >= 0) begin
          slot_busy[slot] = 1'b0;
        end
        chk_cnt += 3;
        assert (host_rsp_rdata_o == exp_data)
          else report_mismatch("host_rsp_rdata_o", host_rsp_rdata_o, exp_data);
        assert (host_rsp_err_o == exp_err)
          else report_mismatch("host_rsp_err_o", data_t'(host_rsp_err_o), data_t'(exp_err));
        assert (host_rsp_id_o == exp_id)
          else report_mismatch("host_rsp_id_o", data_t'(host_rsp_id_o), data_t'(exp_id));
      end
    end
  end

  // external target answers with the inverted address after 0 to 5 cycles
  always @(posedge clk_i) begin : ext_target
    addr_t next_addr;
    #2;
    ext_req_ready_i = ({$random(rsp_seed)} % 4) != 0;
    if (ext_taken) begin
      ext_rsp_valid_i = 1'b0;
      ext_taken = 1'b0;
    end
    if (!ext_rsp_valid_i && ext_addr_q.size() > 0) begin
      if (ext_wait < 0) begin
        ext_wait = {$random(rsp_seed)} % 6;
      end
      if (ext_wait == 0) begin
        next_addr = ext_addr_q.pop_front();
        ext_rsp_valid_i = 1'b1;
        ext_rsp_rdata_i = {32'h0, ~next_addr};
        ext_wait = -1;
      end else begin
        ext_wait--;
      end
    end
  end

  initial begin : stimulus
    int errs;
    arst_n_i         = 1'b0;
    host_req_valid_i = 1'b0;
    host_req_addr_i  = '0;
    host_req_we_i    = 1'b0;
    host_req_wdata_i = '0;
    host_req_strb_i  = '0;
    host_req_id_i    = '0;
    host_rsp_ready_i = 1'b1;
    ext_req_ready_i  = 1'b1;
    ext_rsp_valid_i  = 1'b0;
    ext_rsp_rdata_i  = '0;
    ext_rsp_err_i    = 1'b0;

    errs = total_errors();
    repeat (2) begin
      @(posedge clk_i);
      #2;
      chk_cnt++;
      assert (!host_rsp_valid_o && !ext_req_valid_o)
        else report_error("valid output high during reset");
    end
    arst_n_i = 1'b1;
    @(negedge clk_i);
    chk_cnt++;
    assert (host_req_ready_o && !host_rsp_valid_o && !ext_req_valid_o)
      else report_error("wrong output state right after reset");
    @(posedge clk_i);
    #2;
    send_req(L2_BASE_ADDR, 1'b1, '1);
    @(negedge clk_i);
    chk_cnt++;
    assert (host_rsp_valid_o) else report_error("no L2 response one cycle after acceptance");
    @(posedge clk_i);
    #2;
    wait_drain();
    end_test("reset_state", errs);

    // full write, partial write, read back
    errs = total_errors();
    for (int i = 0; i < 4; i++) begin
      send_req(addr_t'(L2_BASE_ADDR + (L2_SIZE - 8) * i / 3), 1'b1, '1);
      send_req(addr_t'(L2_BASE_ADDR + (L2_SIZE - 8) * i / 3), 1'b1, strb_t'(8'h5a ^ i));
      send_req(addr_t'(L2_BASE_ADDR + (L2_SIZE - 8) * i / 3), 1'b0, '0);
    end
    wait_drain();
    end_test("l2_write_read", errs);

    errs = total_errors();
    for (int i = 0; i < 6; i++) begin
      send_req(EXT_BASE_ADDR | addr_t'($random(seed)), i[0], strb_t'($random(seed)));
    end
    wait_drain();
    end_test("external_window", errs);

    errs = total_errors();
    send_req(32'h0000_1000, 1'b0, '0);
    send_req(addr_t'(L2_BASE_ADDR + L2_SIZE), 1'b1, '1);
    send_req(EXT_BASE_ADDR - 1, 1'b0, '0);
    wait_drain();
    end_test("decode_error", errs);

    // four in flight with the host stalled and then a mixed stream
    errs = total_errors();
    host_rsp_ready_i = 1'b0;
    send_req(L2_BASE_ADDR, 1'b0, '0);
    for (int i = 0; i < 3; i++) begin
      send_req(EXT_BASE_ADDR | addr_t'($random(seed)), 1'b0, '0);
    end
    drive_req(32'h0000_0100, 1'b0, '0);
    repeat (6) begin
      @(negedge clk_i);
      chk_cnt++;
      assert (!host_req_ready_o) else report_error("fifth request accepted with four in flight");
    end
    @(posedge clk_i);
    #2;
    host_rsp_ready_i = 1'b1;
    wait_accept();
    for (int i = 0; i < 12; i++) begin
      case ({$random(seed)} % 3)
        0: send_req(addr_t'(L2_BASE_ADDR + 8 * i), 1'b1, strb_t'($random(seed)));
        1: send_req(EXT_BASE_ADDR | addr_t'($random(seed)), 1'b0, '0);
        default: send_req(32'h0000_2000, 1'b0, '0);
      endcase
    end
    wait_drain();
    end_test("back_pressure", errs);

    $display("checks %0d, errors %0d", chk_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
verilog/soc_cfg_pkg.sv
verilog/soc_bus_pkg.sv
verilog/soc_bus_if.sv
verilog/id_remap.sv
verilog/soc_bus.sv
verilog/l2_mem.sv
verilog/pulp_soc.sv
tests/pulp_soc_properties.sv
tests/tb_pulp_soc.sv

/* run.sh */
#!/bin/sh
# build and run the SoC fabric testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_pulp_soc -o sim_tb_pulp_soc
./obj_dir/sim_tb_pulp_soc +verilator+error+limit+1000 | tee sim.log
if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
echo "simulation reported a failure, see sim.log"
exit 1
